// ==== axi_lite_cdc.f ====
hdl/axi_lite_pkg.sv
hdl/cdc_pkg.sv
hdl/cdc_fifo_src.sv
hdl/cdc_fifo_dst.sv
hdl/cdc_fifo_gray.sv
hdl/axi_lite_cdc.sv
test/axi_lite_cdc_checker.sv
test/tb_axi_lite_cdc.sv

// ==== hdl/axi_lite_cdc.sv ====
/* AXI4-Lite clock domain crossing */
`timescale 1ns/1ps

module axi_lite_cdc
  import axi_lite_pkg::*;
(
  // Manager side, src_clk_i domain
  input  logic  src_clk_i,
  input  req_t  src_req_i,
  output resp_t src_resp_o,
  // Subordinate side, dst_clk_i domain
  input  logic  dst_clk_i,
  output req_t  dst_req_o,
  input  resp_t dst_resp_i,
  input  logic  arst_n_i
);

  // Write side ready per channel
  logic     aw_wr_ready;
  logic     w_wr_ready;
  logic     b_wr_ready;
  logic     ar_wr_ready;
  logic     r_wr_ready;
  // Read side payload and valid per channel
  aw_chan_t aw_rd_data;
  logic     aw_rd_valid;
  w_chan_t  w_rd_data;
  logic     w_rd_valid;
  b_chan_t  b_rd_data;
  logic     b_rd_valid;
  ar_chan_t ar_rd_data;
  logic     ar_rd_valid;
  r_chan_t  r_rd_data;
  logic     r_rd_valid;

  cdc_fifo_gray #(
    .payload_t   ( aw_chan_t            )
  ) i_cdc_fifo_gray_aw (
    .src_clk_i   ( src_clk_i            ),
    .arst_n_i    ( arst_n_i             ),
    .dst_clk_i   ( dst_clk_i            ),
    .src_data_i  ( src_req_i.aw         ),
    .src_valid_i ( src_req_i.aw_valid   ),
    .src_ready_o ( aw_wr_ready          ),
    .dst_data_o  ( aw_rd_data           ),
    .dst_valid_o ( aw_rd_valid          ),
    .dst_ready_i ( dst_resp_i.aw_ready  )
  );

  cdc_fifo_gray #(
    .payload_t   ( w_chan_t             )
  ) i_cdc_fifo_gray_w (
    .src_clk_i   ( src_clk_i            ),
    .arst_n_i    ( arst_n_i             ),
    .dst_clk_i   ( dst_clk_i            ),
    .src_data_i  ( src_req_i.w          ),
    .src_valid_i ( src_req_i.w_valid    ),
    .src_ready_o ( w_wr_ready           ),
    .dst_data_o  ( w_rd_data            ),
    .dst_valid_o ( w_rd_valid           ),
    .dst_ready_i ( dst_resp_i.w_ready   )
  );

  // Responses run the other way, write side in the dst domain
  cdc_fifo_gray #(
    .payload_t   ( b_chan_t             )
  ) i_cdc_fifo_gray_b (
    .src_clk_i   ( dst_clk_i            ),
    .arst_n_i    ( arst_n_i             ),
    .dst_clk_i   ( src_clk_i            ),
    .src_data_i  ( dst_resp_i.b         ),
    .src_valid_i ( dst_resp_i.b_valid   ),
    .src_ready_o ( b_wr_ready           ),
    .dst_data_o  ( b_rd_data            ),
    .dst_valid_o ( b_rd_valid           ),
    .dst_ready_i ( src_req_i.b_ready    )
  );

  cdc_fifo_gray #(
    .payload_t   ( ar_chan_t            )
  ) i_cdc_fifo_gray_ar (
    .src_clk_i   ( src_clk_i            ),
    .arst_n_i    ( arst_n_i             ),
    .dst_clk_i   ( dst_clk_i            ),
    .src_data_i  ( src_req_i.ar         ),
    .src_valid_i ( src_req_i.ar_valid   ),
    .src_ready_o ( ar_wr_ready          ),
    .dst_data_o  ( ar_rd_data           ),
    .dst_valid_o ( ar_rd_valid          ),
    .dst_ready_i ( dst_resp_i.ar_ready  )
  );

  cdc_fifo_gray #(
    .payload_t   ( r_chan_t             )
  ) i_cdc_fifo_gray_r (
    .src_clk_i   ( dst_clk_i            ),
    .arst_n_i    ( arst_n_i             ),
    .dst_clk_i   ( src_clk_i            ),
    .src_data_i  ( dst_resp_i.r         ),
    .src_valid_i ( dst_resp_i.r_valid   ),
    .src_ready_o ( r_wr_ready           ),
    .dst_data_o  ( r_rd_data            ),
    .dst_valid_o ( r_rd_valid           ),
    .dst_ready_i ( src_req_i.r_ready    )
  );

  // Bundle back towards the manager
  always_comb begin
    src_resp_o.aw_ready = aw_wr_ready;
    src_resp_o.w_ready  = w_wr_ready;
    src_resp_o.b        = b_rd_data;
    src_resp_o.b_valid  = b_rd_valid;
    src_resp_o.ar_ready = ar_wr_ready;
    src_resp_o.r        = r_rd_data;
    src_resp_o.r_valid  = r_rd_valid;
  end

  // Bundle towards the subordinate
  always_comb begin
    dst_req_o.aw       = aw_rd_data;
    dst_req_o.aw_valid = aw_rd_valid;
    dst_req_o.w        = w_rd_data;
    dst_req_o.w_valid  = w_rd_valid;
    dst_req_o.b_ready  = b_wr_ready;
    dst_req_o.ar       = ar_rd_data;
    dst_req_o.ar_valid = ar_rd_valid;
    dst_req_o.r_ready  = r_wr_ready;
  end

endmodule

// ==== hdl/axi_lite_pkg.sv ====
/* AXI4-Lite channel and bundle types */
package axi_lite_pkg;

  // Field types
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [2:0]  prot_t;
  typedef logic [1:0]  resp_code_t;

  // Write address channel
  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } aw_chan_t;

  // Write data channel
  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_chan_t;

  // Write response channel
  typedef struct packed {
    resp_code_t resp;
  } b_chan_t;

  // Read address channel
  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } ar_chan_t;

  // Read data channel
  typedef struct packed {
    data_t      data;
    resp_code_t resp;
  } r_chan_t;

  // Everything a manager drives
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } req_t;

  // Everything a subordinate drives
  typedef struct packed {
    logic     aw_ready;
    logic     w_ready;
    b_chan_t  b;
    logic     b_valid;
    logic     ar_ready;
    r_chan_t  r;
    logic     r_valid;
  } resp_t;

endpackage

// ==== hdl/cdc_fifo_dst.sv ====
/* Gray FIFO read half */
`timescale 1ns/1ps

module cdc_fifo_dst
  import cdc_pkg::*;
#(
  parameter type payload_t = logic
) (
  input  logic                 rd_clk_i,
  input  logic                 arst_n_i,
  input  ptr_t                 wr_ptr_gray_i,
  output ptr_t                 rd_ptr_gray_o,
  output logic [LOG_DEPTH-1:0] rd_addr_o,
  input  payload_t             rd_data_i,
  output payload_t             rd_data_o,
  output logic                 rd_valid_o,
  input  logic                 rd_ready_i
);

  ptr_t [SYNC_STAGES-1:0] wr_sync_q;
  ptr_t                   wr_ptr_gray_sync;
  ptr_t                   rd_ptr_gray_q;
  ptr_t                   rd_ptr_bin;
  ptr_t                   rd_ptr_bin_next;
  ptr_t                   rd_ptr_gray_next;
  logic                   pop;
  logic                   valid_q;
  payload_t               data_q;

  // Write pointer into the read clock
  always_ff @(posedge rd_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_sync_q <= '0;
    end else begin
      wr_sync_q <= {wr_sync_q[SYNC_STAGES-2:0], wr_ptr_gray_i};
    end
  end

  assign wr_ptr_gray_sync = wr_sync_q[SYNC_STAGES-1];

  // Binary form of the read pointer follows from the gray register
  assign rd_ptr_bin       = gray2bin(rd_ptr_gray_q);
  assign pop              = valid_q & rd_ready_i;
  assign rd_ptr_bin_next  = pop ? rd_ptr_bin + ptr_t'(1) : rd_ptr_bin;
  assign rd_ptr_gray_next = bin2gray(rd_ptr_bin_next);

  // Look ahead one entry so the output register holds the head
  assign rd_addr_o = rd_ptr_bin_next[LOG_DEPTH-1:0];

  always_ff @(posedge rd_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_ptr_gray_q <= '0;
      valid_q       <= 1'b0;
    end else begin
      rd_ptr_gray_q <= rd_ptr_gray_next;
      // Not empty when pointers differ in gray
      valid_q       <= (rd_ptr_gray_next != wr_ptr_gray_sync);
    end
  end

  // Head payload, reloaded every cycle; same slot while nothing is popped
  always_ff @(posedge rd_clk_i) begin
    data_q <= rd_data_i;
  end

  assign rd_ptr_gray_o = rd_ptr_gray_q;
  assign rd_data_o     = data_q;
  assign rd_valid_o    = valid_q;

endmodule

// ==== hdl/cdc_fifo_gray.sv ====
/* Dual-clock gray pointer FIFO */
`timescale 1ns/1ps

module cdc_fifo_gray
  import cdc_pkg::*;
#(
  parameter type payload_t = logic
) (
  input  logic     src_clk_i,
  input  logic     arst_n_i,
  input  logic     dst_clk_i,
  input  payload_t src_data_i,
  input  logic     src_valid_i,
  output logic     src_ready_o,
  output payload_t dst_data_o,
  output logic     dst_valid_o,
  input  logic     dst_ready_i
);

  ptr_t                 wr_ptr_gray;
  ptr_t                 rd_ptr_gray;
  logic [LOG_DEPTH-1:0] rd_addr;
  payload_t             rd_data;

  // Push side with storage
  cdc_fifo_src #(
    .payload_t     ( payload_t   )
  ) i_src (
    .wr_clk_i      ( src_clk_i   ),
    .arst_n_i      ( arst_n_i    ),
    .wr_data_i     ( src_data_i  ),
    .wr_valid_i    ( src_valid_i ),
    .wr_ready_o    ( src_ready_o ),
    .rd_ptr_gray_i ( rd_ptr_gray ),
    .wr_ptr_gray_o ( wr_ptr_gray ),
    .rd_addr_i     ( rd_addr     ),
    .rd_data_o     ( rd_data     )
  );

  // Pop side
  cdc_fifo_dst #(
    .payload_t     ( payload_t   )
  ) i_dst (
    .rd_clk_i      ( dst_clk_i   ),
    .arst_n_i      ( arst_n_i    ),
    .wr_ptr_gray_i ( wr_ptr_gray ),
    .rd_ptr_gray_o ( rd_ptr_gray ),
    .rd_addr_o     ( rd_addr     ),
    .rd_data_i     ( rd_data     ),
    .rd_data_o     ( dst_data_o  ),
    .rd_valid_o    ( dst_valid_o ),
    .rd_ready_i    ( dst_ready_i )
  );

endmodule

// ==== hdl/cdc_fifo_src.sv ====
/* Gray FIFO write half */
`timescale 1ns/1ps

module cdc_fifo_src
  import cdc_pkg::*;
#(
  parameter type payload_t = logic
) (
  input  logic                 wr_clk_i,
  input  logic                 arst_n_i,
  input  payload_t             wr_data_i,
  input  logic                 wr_valid_i,
  output logic                 wr_ready_o,
  input  ptr_t                 rd_ptr_gray_i,
  output ptr_t                 wr_ptr_gray_o,
  input  logic [LOG_DEPTH-1:0] rd_addr_i,
  output payload_t             rd_data_o
);

  payload_t               mem_q [DEPTH];
  ptr_t                   wr_ptr_bin_q;
  ptr_t                   wr_ptr_bin_next;
  ptr_t                   wr_ptr_gray_q;
  ptr_t [SYNC_STAGES-1:0] rd_sync_q;
  ptr_t                   rd_ptr_gray_sync;
  ptr_t                   full_ptr;
  logic                   full;
  logic                   push;

  // Read pointer into the write clock
  always_ff @(posedge wr_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_sync_q <= '0;
    end else begin
      rd_sync_q <= {rd_sync_q[SYNC_STAGES-2:0], rd_ptr_gray_i};
    end
  end

  assign rd_ptr_gray_sync = rd_sync_q[SYNC_STAGES-1];

  // Full when the top two gray bits differ and the rest match
  assign full_ptr   = {~rd_ptr_gray_sync[PTR_W-1:PTR_W-2], rd_ptr_gray_sync[PTR_W-3:0]};
  assign full       = (wr_ptr_gray_q == full_ptr);
  assign wr_ready_o = ~full;
  assign push       = wr_valid_i & wr_ready_o;

  assign wr_ptr_bin_next = wr_ptr_bin_q + ptr_t'(1);

  always_ff @(posedge wr_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_bin_q  <= '0;
      wr_ptr_gray_q <= '0;
    end else if (push) begin
      wr_ptr_bin_q  <= wr_ptr_bin_next;
      // Gray copy is registered so only one bit toggles across the crossing
      wr_ptr_gray_q <= bin2gray(wr_ptr_bin_next);
    end
  end

  assign wr_ptr_gray_o = wr_ptr_gray_q;

  // Storage
  always_ff @(posedge wr_clk_i) begin
    if (push) begin
      mem_q[wr_ptr_bin_q[LOG_DEPTH-1:0]] <= wr_data_i;
    end
  end

  // Read port for the far half, slot is stable once its pointer is seen there
  assign rd_data_o = mem_q[rd_addr_i];

endmodule

// ==== hdl/cdc_pkg.sv ====
/* Gray pointer FIFO constants and helpers */
package cdc_pkg;

  // FIFO geometry
  localparam int unsigned LOG_DEPTH   = 2;
  localparam int unsigned DEPTH       = 1 << LOG_DEPTH;
  // One extra bit tells a full FIFO from an empty one
  localparam int unsigned PTR_W       = LOG_DEPTH + 1;
  localparam int unsigned SYNC_STAGES = 2;

  typedef logic [PTR_W-1:0] ptr_t;

  // Binary to gray
  function automatic ptr_t bin2gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // Gray to binary, prefix XOR from the top bit down
  function automatic ptr_t gray2bin(input ptr_t gray);
    ptr_t bin;
    bin[PTR_W-1] = gray[PTR_W-1];
    for (int i = PTR_W - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

// ==== test/axi_lite_cdc_checker.sv ====
/* AXI4-Lite crossing checker */
`timescale 1ns/1ps

module axi_lite_cdc_checker
  import axi_lite_pkg::*;
  import cdc_pkg::*;
(
  input  logic             src_clk_i,
  input  logic             dst_clk_i,
  input  logic             arst_n_i,
  input  req_t             src_req_i,
  input  resp_t            src_resp_i,
  input  req_t             dst_req_i,
  input  resp_t            dst_resp_i,
  // Bit 0 AW held by the subordinate, bit 1 R held by the manager
  input  logic [1:0]       stall_i,
  output int unsigned      err_cnt_o,
  output logic [4:0][15:0] delivered_o,
  output logic             idle_o
);

  // Reference model, one queue per channel in write order
  logic [35:0] aw_q[$];
  logic [35:0] w_q[$];
  logic [35:0] b_q[$];
  logic [35:0] ar_q[$];
  logic [35:0] r_q[$];
  logic [15:0] aw_cnt = '0;
  logic [15:0] w_cnt = '0;
  logic [15:0] b_cnt = '0;
  logic [15:0] ar_cnt = '0;
  logic [15:0] r_cnt = '0;
  logic        aw_stall_q = 1'b0;
  logic        r_stall_q = 1'b0;
  int unsigned errs = 0;

  task automatic fail(input string what);
    $display("ERROR %0t: %s", $time, what);
    errs++;
  endtask

  task automatic compare(input string chan, input logic [35:0] exp_v, input logic [35:0] got_v);
    if (got_v !== exp_v) begin
      fail($sformatf("%s payload %h, expected %h", chan, got_v, exp_v));
    end
  endtask

  // All FIFOs are empty when reset is released
  always @(posedge arst_n_i) begin
    if (src_resp_i.b_valid || src_resp_i.r_valid || dst_req_i.aw_valid ||
        dst_req_i.w_valid || dst_req_i.ar_valid)
      fail("a valid output is high right after reset");
    if (!(src_resp_i.aw_ready && src_resp_i.w_ready && src_resp_i.ar_ready &&
          dst_req_i.b_ready && dst_req_i.r_ready))
      fail("a ready toward a writer is low right after reset");
  end

  // Manager side, AW W AR accepted and B R delivered
  always @(posedge src_clk_i) begin
    if (arst_n_i) begin
      if (aw_q.size() >= DEPTH && src_resp_i.aw_ready)
        fail("AW ready stayed high with DEPTH beats outstanding");
      if (aw_stall_q && !stall_i[0] && aw_q.size() != DEPTH)
        fail($sformatf("AW FIFO took %0d beats under back-pressure", aw_q.size()));
      aw_stall_q <= stall_i[0];
      if (src_req_i.aw_valid && src_resp_i.aw_ready)
        aw_q.push_back(src_req_i.aw);
      if (src_req_i.w_valid && src_resp_i.w_ready)
        w_q.push_back(src_req_i.w);
      if (src_req_i.ar_valid && src_resp_i.ar_ready)
        ar_q.push_back(src_req_i.ar);
      if (src_resp_i.b_valid && src_req_i.b_ready) begin
        if (b_q.size() == 0)
          fail("B beat appeared that was never sent");
        else
          compare("B", b_q.pop_front(), src_resp_i.b);
        b_cnt <= b_cnt + 1'b1;
      end
      if (src_resp_i.r_valid && src_req_i.r_ready) begin
        if (r_q.size() == 0)
          fail("R beat appeared that was never sent");
        else
          compare("R", r_q.pop_front(), src_resp_i.r);
        r_cnt <= r_cnt + 1'b1;
      end
      idle_o <= (aw_q.size() + w_q.size() + b_q.size() + ar_q.size() + r_q.size()) == 0;
    end
  end

  // Subordinate side, B R accepted and AW W AR delivered
  always @(posedge dst_clk_i) begin
    if (arst_n_i) begin
      if (r_q.size() >= DEPTH && dst_req_i.r_ready)
        fail("R ready stayed high with DEPTH beats outstanding");
      if (r_stall_q && !stall_i[1] && r_q.size() != DEPTH)
        fail($sformatf("R FIFO took %0d beats under back-pressure", r_q.size()));
      r_stall_q <= stall_i[1];
      if (dst_resp_i.b_valid && dst_req_i.b_ready)
        b_q.push_back(dst_resp_i.b);
      if (dst_resp_i.r_valid && dst_req_i.r_ready)
        r_q.push_back(dst_resp_i.r);
      if (dst_req_i.aw_valid && dst_resp_i.aw_ready) begin
        if (aw_q.size() == 0)
          fail("AW beat appeared that was never sent");
        else
          compare("AW", aw_q.pop_front(), dst_req_i.aw);
        aw_cnt <= aw_cnt + 1'b1;
      end
      if (dst_req_i.w_valid && dst_resp_i.w_ready) begin
        if (w_q.size() == 0)
          fail("W beat appeared that was never sent");
        else
          compare("W", w_q.pop_front(), dst_req_i.w);
        w_cnt <= w_cnt + 1'b1;
      end
      if (dst_req_i.ar_valid && dst_resp_i.ar_ready) begin
        if (ar_q.size() == 0)
          fail("AR beat appeared that was never sent");
        else
          compare("AR", ar_q.pop_front(), dst_req_i.ar);
        ar_cnt <= ar_cnt + 1'b1;
      end
    end
  end

  assign err_cnt_o   = errs;
  assign delivered_o = {r_cnt, ar_cnt, b_cnt, w_cnt, aw_cnt};

endmodule

// ==== test/tb_axi_lite_cdc.sv ====
/* AXI4-Lite crossing testbench */
`timescale 1ns/1ps

module tb_axi_lite_cdc
  import axi_lite_pkg::*;
();

  localparam int unsigned N_BEATS    = 200;
  // 40 periods of the slow clock per beat and channel
  localparam int unsigned TIMEOUT_NS = N_BEATS * 40 * 13;

  logic             src_clk = 1'b0;
  logic             dst_clk = 1'b0;
  logic             arst_n = 1'b0;
  req_t             src_req;
  resp_t            src_resp;
  req_t             dst_req;
  resp_t            dst_resp;
  logic [1:0]       stall;
  logic             hold_aw;
  logic             hold_r;
  logic [15:0]      src_lfsr;
  logic [15:0]      dst_lfsr;
  int unsigned      err_cnt;
  logic [4:0][15:0] delivered;
  logic             idle;

  always #4 src_clk = ~src_clk;
  always #6.5 dst_clk = ~dst_clk;

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw(inout logic [15:0] state, input int n, output logic [35:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      state = lfsr_step(state);
      bits  = {bits[34:0], state[0]};
    end
  endtask

  // Drop valid after a transfer and raise it again now and then with a new payload
  task automatic offer(inout logic [15:0] state, input int width, input logic fire,
                       inout int unsigned sent, inout logic valid, inout logic [35:0] data);
    logic [35:0] rnd;
    if (fire) begin
      valid = 1'b0;
      sent++;
    end
    if (!valid && sent < N_BEATS) begin
      draw(state, 2, rnd);
      if (rnd[1:0] != 2'b00) begin
        draw(state, width, data);
        valid = 1'b1;
      end
    end
  endtask

  function automatic logic all_delivered(input logic [4:0][15:0] cnt);
    logic done;
    done = 1'b1;
    for (int i = 0; i < 5; i++) begin
      if (cnt[i] < N_BEATS)
        done = 1'b0;
    end
    return done;
  endfunction

  axi_lite_cdc UUT (
    .src_clk_i  ( src_clk  ),
    .src_req_i  ( src_req  ),
    .src_resp_o ( src_resp ),
    .dst_clk_i  ( dst_clk  ),
    .dst_req_o  ( dst_req  ),
    .dst_resp_i ( dst_resp ),
    .arst_n_i   ( arst_n   )
  );

  axi_lite_cdc_checker i_checker (
    .src_clk_i   ( src_clk   ),
    .dst_clk_i   ( dst_clk   ),
    .arst_n_i    ( arst_n    ),
    .src_req_i   ( src_req   ),
    .src_resp_i  ( src_resp  ),
    .dst_req_i   ( dst_req   ),
    .dst_resp_i  ( dst_resp  ),
    .stall_i     ( stall     ),
    .err_cnt_o   ( err_cnt   ),
    .delivered_o ( delivered ),
    .idle_o      ( idle      )
  );

  // Manager with AW, W and AR beats and random B and R ready
  initial begin : src_driver
    logic        aw_fire;
    logic        w_fire;
    logic        ar_fire;
    logic [35:0] aw_d;
    logic [35:0] w_d;
    logic [35:0] ar_d;
    logic [35:0] rnd;
    int unsigned aw_sent;
    int unsigned w_sent;
    int unsigned ar_sent;
    aw_sent = 0;
    w_sent  = 0;
    ar_sent = 0;
    aw_d    = '0;
    w_d     = '0;
    ar_d    = '0;
    @(posedge arst_n);
    forever begin
      @(posedge src_clk);
      aw_fire = src_req.aw_valid && src_resp.aw_ready;
      w_fire  = src_req.w_valid && src_resp.w_ready;
      ar_fire = src_req.ar_valid && src_resp.ar_ready;
      @(negedge src_clk);
      offer(src_lfsr, 35, aw_fire, aw_sent, src_req.aw_valid, aw_d);
      src_req.aw = aw_d[34:0];
      offer(src_lfsr, 36, w_fire, w_sent, src_req.w_valid, w_d);
      src_req.w = w_d;
      offer(src_lfsr, 35, ar_fire, ar_sent, src_req.ar_valid, ar_d);
      src_req.ar = ar_d[34:0];
      draw(src_lfsr, 2, rnd);
      src_req.b_ready = (rnd[1:0] != 2'b00);
      draw(src_lfsr, 2, rnd);
      src_req.r_ready = !hold_r && (rnd[1:0] != 2'b00);
    end
  end

  // Subordinate with B and R beats and random AW, W and AR ready
  initial begin : dst_driver
    logic        b_fire;
    logic        r_fire;
    logic [35:0] b_d;
    logic [35:0] r_d;
    logic [35:0] rnd;
    int unsigned b_sent;
    int unsigned r_sent;
    b_sent = 0;
    r_sent = 0;
    b_d    = '0;
    r_d    = '0;
    @(posedge arst_n);
    forever begin
      @(posedge dst_clk);
      b_fire = dst_resp.b_valid && dst_req.b_ready;
      r_fire = dst_resp.r_valid && dst_req.r_ready;
      @(negedge dst_clk);
      offer(dst_lfsr, 2, b_fire, b_sent, dst_resp.b_valid, b_d);
      dst_resp.b = b_d[1:0];
      offer(dst_lfsr, 34, r_fire, r_sent, dst_resp.r_valid, r_d);
      dst_resp.r = r_d[33:0];
      draw(dst_lfsr, 2, rnd);
      dst_resp.aw_ready = !hold_aw && (rnd[1:0] != 2'b00);
      draw(dst_lfsr, 2, rnd);
      dst_resp.w_ready = (rnd[1:0] != 2'b00);
      draw(dst_lfsr, 2, rnd);
      dst_resp.ar_ready = (rnd[1:0] != 2'b00);
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the crossing did not deliver all beats within %0d ns", TIMEOUT_NS);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    src_req  = '0;
    dst_resp = '0;
    stall    = 2'b00;
    hold_aw  = 1'b0;
    hold_r   = 1'b0;
    src_lfsr = 16'd75;
    dst_lfsr = 16'd75;
    repeat (10) @(negedge src_clk);
    arst_n = 1'b1;
    // Subordinate holds AW ready low until the FIFO has filled
    repeat (40) @(negedge src_clk);
    hold_aw  = 1'b1;
    stall[0] = 1'b1;
    repeat (40) @(negedge src_clk);
    stall[0] = 1'b0;
    @(negedge src_clk);
    hold_aw = 1'b0;
    // Manager holds R ready low
    repeat (20) @(negedge dst_clk);
    hold_r   = 1'b1;
    stall[1] = 1'b1;
    repeat (30) @(negedge dst_clk);
    stall[1] = 1'b0;
    @(negedge dst_clk);
    hold_r = 1'b0;
    while (!(idle && all_delivered(delivered)))
      @(negedge src_clk);
    // A few more cycles to catch late duplicates
    repeat (20) @(negedge src_clk);
    $display("Beats AW %0d W %0d B %0d AR %0d R %0d, errors %0d", delivered[0],
             delivered[1], delivered[2], delivered[3], delivered[4], err_cnt);
    if (err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
